// ==== dv/exec_cluster_tb.sv ====
module exec_cluster_tb
    import rv32_pkg::*;
    import exec_pkg::*;
();

    localparam int SS      = 2;
    localparam int TIMEOUT = 200;

    localparam alu_op_t ALU_OPS [10] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                                         alu_xor, alu_srl, alu_sra, alu_or, alu_and};
    localparam cmp_op_t CMP_OPS [6] = '{cmp_beq, cmp_bne, cmp_blt, cmp_bge, cmp_bltu, cmp_bgeu};
    localparam mul_type_t MUL_OPS [4] = '{mul_mul, mul_mulh, mul_mulhsu, mul_mulhu};

    // Equal, signed-negative and unsigned-large operand pairs
    localparam logic [31:0] BR_A [3] = '{32'd5, 32'hffff_fff0, 32'd1};
    localparam logic [31:0] BR_B [3] = '{32'd5, 32'd3, 32'h8000_0000};

    logic    clk;
    logic    rst;
    logic    issue_valid [SS];
    logic    issue_ready [SS];
    issue_t  issue_inst  [SS];
    logic    cdb_valid;
    logic    cdb_ready;
    result_t cdb_result;

    integer     seed;
    result_t    expected  [2**TAG_W];
    logic       in_flight [2**TAG_W];
    logic [1:0] tag_cnt   [SS];
    int         issued;
    int         retired;
    logic       bp_on;
    logic       rr_check;
    logic       rr_first;
    logic       last_lane;

    exec_cluster #(
        .SS (SS)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_inst  (issue_inst),
        .cdb_valid   (cdb_valid),
        .cdb_ready   (cdb_ready),
        .cdb_result  (cdb_result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic signed_less(logic [31:0] a, logic [31:0] b);
        // Differing signs decide on their own
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [31:0] alu_ref(alu_op_t op, logic [31:0] a, logic [31:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << b[4:0];
            alu_slt:  return {31'd0, signed_less(a, b)};
            alu_sltu: return {31'd0, a < b};
            alu_xor:  return a ^ b;
            alu_srl:  return a >> b[4:0];
            alu_sra:  return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
            alu_or:   return a | b;
            alu_and:  return a & b;
            default:  return 32'd0;
        endcase
    endfunction

    function automatic result_t expected_result(issue_t inst);
        result_t     r;
        logic [31:0] x;
        logic [31:0] y;
        logic        a_sext;
        logic        b_sext;
        logic [63:0] prod;
        x = (inst.rs1_s == '0) ? 32'd0 : inst.rs1_value;
        y = (inst.rs2_s == '0) ? 32'd0 : inst.rs2_value;
        r.tag            = inst.tag;
        r.br_en          = 1'b0;
        r.register_value = 32'd0;
        if (inst.is_mul) begin
            // Product of the sign or zero extended operands, modulo 2**64
            a_sext = x[31] && (inst.mul_type != mul_mulhu);
            b_sext = y[31] && ((inst.mul_type == mul_mul) || (inst.mul_type == mul_mulh));
            prod   = {{32{a_sext}}, x} * {{32{b_sext}}, y};
            r.register_value = (inst.mul_type == mul_mul) ? prod[31:0] : prod[63:32];
        end else begin
            case (inst.op_class)
                op_reg:   r.register_value = alu_ref(inst.alu_operation, x, y);
                op_imm:   r.register_value = alu_ref(inst.alu_operation, x, inst.immediate);
                op_auipc: r.register_value = inst.pc_curr + inst.immediate;
                op_lui:   r.register_value = inst.immediate;
                op_jump:  r.register_value = inst.pc_curr + 32'd4;
                op_branch: begin
                    r.register_value = inst.pc_curr + inst.immediate;
                    case (inst.cmp_operation)
                        cmp_beq:  r.br_en = (x == y);
                        cmp_bne:  r.br_en = (x != y);
                        cmp_blt:  r.br_en = signed_less(x, y);
                        cmp_bge:  r.br_en = !signed_less(x, y);
                        cmp_bltu: r.br_en = (x < y);
                        cmp_bgeu: r.br_en = !(x < y);
                        default:  r.br_en = 1'b0;
                    endcase
                end
                default: r.register_value = 32'd0;
            endcase
        end
        return r;
    endfunction

    function automatic issue_t build_alu(op_class_t cls, alu_op_t op, logic [31:0] a,
                                         logic [31:0] b);
        issue_t inst;
        inst               = '0;
        inst.op_class      = cls;
        inst.alu_en        = 1'b1;
        inst.alu_operation = op;
        inst.rs1_s         = 5'd1;
        inst.rs2_s         = 5'd2;
        inst.op2_is_imm    = (cls != op_reg);
        inst.rs1_value     = a;
        // Immediate forms see b only through the immediate
        inst.rs2_value     = (cls == op_reg) ? b : ~b;
        inst.immediate     = b;
        inst.pc_curr       = rnd() & 32'hffff_fffc;
        return inst;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic issue_one(input int lane, input issue_t inst);
        int waited;
        inst.tag          = {tag_cnt[lane], lane[0]};
        tag_cnt[lane]     = tag_cnt[lane] + 2'd1;
        issue_inst[lane]  = inst;
        issue_valid[lane] = 1'b1;
        waited            = 0;
        @(negedge clk);
        while (!issue_ready[lane]) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_now($sformatf("lane %0d never accepted an instruction", lane));
            end
            @(negedge clk);
        end
        expected[inst.tag]  = expected_result(inst);
        in_flight[inst.tag] = 1'b1;
        issued++;
        @(posedge clk);
        #5;
        issue_valid[lane] = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (retired != issued) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                fail_now("results still missing from the CDB after the timeout");
            end
        end
        @(posedge clk);
        #5;
    endtask

    task automatic run_alu_tests(input int lane, input int count);
        for (int n = 0; n < count; n++) begin
            issue_one(lane, build_alu((rnd() & 32'd1) != 0 ? op_imm : op_reg,
                                      ALU_OPS[4'(rnd() % 10)], rnd(), rnd()));
        end
        // Shift amounts at and past 31, then slt against sltu
        issue_one(lane, build_alu(op_reg, alu_sra, 32'h8000_0000, 32'd31));
        issue_one(lane, build_alu(op_reg, alu_sll, 32'h0000_0001, 32'd63));
        issue_one(lane, build_alu(op_imm, alu_srl, 32'hffff_ffff, 32'd32));
        issue_one(lane, build_alu(op_reg, alu_slt, 32'hffff_ffff, 32'd1));
        issue_one(lane, build_alu(op_reg, alu_sltu, 32'hffff_ffff, 32'd1));
    endtask

    task automatic run_misc_tests(input int lane);
        issue_t inst;
        // x0 reads as zero with a nonzero value planted
        inst = build_alu(op_reg, alu_add, rnd() | 32'd1, rnd());
        inst.rs1_s = '0;
        issue_one(lane, inst);
        inst = build_alu(op_reg, alu_or, rnd(), rnd() | 32'd1);
        inst.rs2_s = '0;
        issue_one(lane, inst);
        inst = build_alu(op_lui, alu_add, rnd() | 32'd1, rnd());
        inst.rs1_s = '0;
        issue_one(lane, inst);
        inst = build_alu(op_auipc, alu_add, rnd(), rnd());
        inst.op1_is_pc = 1'b1;
        issue_one(lane, inst);
        inst = build_alu(op_jump, alu_add, rnd(), rnd());
        inst.op1_is_pc = 1'b1;
        issue_one(lane, inst);
        for (int k = 0; k < 6; k++) begin
            for (int m = 0; m < 3; m++) begin
                inst = build_alu(op_branch, alu_add, BR_A[m], BR_B[m]);
                inst.cmp_en        = 1'b1;
                inst.op1_is_pc     = 1'b1;
                inst.cmp_operation = CMP_OPS[k];
                // The comparator reads rs2 itself
                inst.rs2_value     = BR_B[m];
                inst.immediate     = rnd();
                issue_one(lane, inst);
            end
        end
        for (int k = 0; k < 4; k++) begin
            for (int m = 0; m < 3; m++) begin
                // Random, then 0x80000000 by -1, then -1 by -1
                inst = build_alu(op_reg, alu_add,
                                 (m == 0) ? rnd() : ((m == 1) ? 32'h8000_0000 : 32'hffff_ffff),
                                 (m == 0) ? rnd() : 32'hffff_ffff);
                inst.alu_en   = 1'b0;
                inst.is_mul   = 1'b1;
                inst.mul_type = MUL_OPS[k];
                issue_one(lane, inst);
            end
        end
    endtask

    task automatic check_mul_hold();
        issue_t inst;
        inst = build_alu(op_reg, alu_add, 32'h8000_0000, 32'hffff_ffff);
        inst.alu_en   = 1'b0;
        inst.is_mul   = 1'b1;
        inst.mul_type = mul_mulh;
        cdb_ready     = 1'b0;
        issue_one(0, inst);
        // 33 cycles of multiply, then the result sits on a stalled CDB
        repeat (40) begin
            @(negedge clk);
            check_value("issue_ready[0]", 32'(issue_ready[0]), 32'd0);
        end
        @(posedge clk);
        #5;
        cdb_ready = 1'b1;
        wait_drain();
        check_value("issue_ready[0]", 32'(issue_ready[0]), 32'd1);
    endtask

    task automatic run_backpressure();
        bp_on    = 1'b1;
        rr_check = 1'b1;
        rr_first = 1'b1;
        fork
            begin
                fork
                    run_alu_tests(0, 16);
                    run_alu_tests(1, 16);
                join
                bp_on = 1'b0;
            end
            while (bp_on) begin
                cdb_ready = 1'b0;
                repeat (1 + rnd() % 12) @(posedge clk);
                #5;
                cdb_ready = 1'b1;
                repeat (1 + rnd() % 3) @(posedge clk);
                #5;
            end
        join
        wait_drain();
        rr_check = 1'b0;
    endtask

    // Transfer happens at the next rising edge, so the negative edge sees stable values
    initial begin
        retired = 0;
        for (int t = 0; t < 2**TAG_W; t++) begin
            in_flight[t] = 1'b0;
        end
        forever begin
            @(negedge clk);
            if (!rst && cdb_valid && cdb_ready) begin
                if (!in_flight[cdb_result.tag]) begin
                    fail_now($sformatf("CDB carried tag %0d with no instruction in flight",
                                       cdb_result.tag));
                end else begin
                    check_value("cdb_result.register_value", cdb_result.register_value,
                                expected[cdb_result.tag].register_value);
                    check_value("cdb_result.br_en", 32'(cdb_result.br_en),
                                32'(expected[cdb_result.tag].br_en));
                    // With both slots kept full the grant switches lane every transfer
                    if (rr_check) begin
                        if (!rr_first) begin
                            check_value("cdb_result.tag lane", 32'(cdb_result.tag[0]),
                                        32'(!last_lane));
                        end
                        rr_first  = 1'b0;
                        last_lane = cdb_result.tag[0];
                    end
                    in_flight[cdb_result.tag] = 1'b0;
                    retired++;
                end
            end
        end
    end

    initial begin
        seed      = 32'hd56d;
        rst       = 1'b1;
        cdb_ready = 1'b0;
        issued    = 0;
        bp_on     = 1'b0;
        rr_check  = 1'b0;
        rr_first  = 1'b1;
        last_lane = 1'b0;
        for (int i = 0; i < SS; i++) begin
            issue_valid[i] = 1'b0;
            issue_inst[i]  = '0;
            tag_cnt[i]     = '0;
        end
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;
        @(negedge clk);
        for (int i = 0; i < SS; i++) begin
            check_value($sformatf("issue_ready[%0d]", i), 32'(issue_ready[i]), 32'd1);
        end
        check_value("cdb_valid", 32'(cdb_valid), 32'd0);
        @(posedge clk);
        #5;
        cdb_ready = 1'b1;
        fork
            run_alu_tests(0, 24);
            run_alu_tests(1, 24);
        join
        wait_drain();
        fork
            run_misc_tests(0);
            run_misc_tests(1);
        join
        wait_drain();
        check_mul_hold();
        run_backpressure();
        $display("Simulation PASSED");
        $finish;
    end

endmodule : exec_cluster_tb

// ==== exec_cluster.f ====
logic/rv32_pkg.sv
logic/exec_pkg.sv
logic/cdb_lane_if.sv
logic/alu.sv
logic/cmp.sv
logic/shift_add_multiplier.sv
logic/fu_wrapper.sv
logic/cdb_arbiter.sv
logic/exec_cluster.sv
dv/exec_cluster_tb.sv

// ==== logic/alu.sv ====
module alu
    import rv32_pkg::*;
(
    input  alu_op_t     aluop,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] f
);

    logic [4:0] shamt;

    // Only the low five bits count for RV32 shifts
    assign shamt = b[4:0];

    always_comb begin
        case (aluop)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            alu_slt:  f = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: f = {31'b0, a < b};
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = $unsigned($signed(a) >>> shamt);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = a + b;
        endcase
    end

endmodule : alu

// ==== logic/cdb_arbiter.sv ====
module cdb_arbiter
    import exec_pkg::*;
#(
    parameter int SS = 2
)
(
    input  logic    clk,
    input  logic    rst,
    cdb_lane_if.arb lanes [SS],
    output logic    cdb_valid,
    input  logic    cdb_ready,
    output result_t cdb_result
);

    localparam int PTR_W = (SS > 1) ? $clog2(SS) : 1;

    logic [SS-1:0]    lane_valid;
    result_t          lane_result [SS];
    logic [SS-1:0]    grant;
    logic [PTR_W-1:0] sel;
    logic [PTR_W-1:0] ptr;

    // Interface arrays need constant indices, so flatten them here
    for (genvar i = 0; i < SS; i++) begin : g_lane
        assign lane_valid[i]  = lanes[i].valid;
        assign lane_result[i] = lanes[i].result;
        assign lanes[i].ready = grant[i] && cdb_ready;
    end

    // First valid lane at or after the pointer
    always_comb begin
        int   idx;
        logic found;
        idx   = 0;
        found = 1'b0;
        grant = '0;
        sel   = '0;
        for (int k = 0; k < SS; k++) begin
            idx = (int'(ptr) + k) % SS;
            if (!found && lane_valid[idx]) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                sel        = PTR_W'(idx);
            end
        end
    end

    assign cdb_valid  = |lane_valid;
    assign cdb_result = lane_result[sel];

    // Pointer moves past the winner only on a completed transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (cdb_valid && cdb_ready) begin
            ptr <= (int'(sel) == SS - 1) ? '0 : sel + 1'b1;
        end
    end

endmodule : cdb_arbiter

// ==== logic/cdb_lane_if.sv ====
interface cdb_lane_if
    import exec_pkg::*;
();

    logic    valid;
    logic    ready;
    result_t result;

    // Result slot side of a lane
    modport lane (
        output valid,
        output result,
        input  ready
    );

    // CDB arbiter side
    modport arb (
        input  valid,
        input  result,
        output ready
    );

endinterface : cdb_lane_if

// ==== logic/cmp.sv ====
module cmp
    import rv32_pkg::*;
(
    input  cmp_op_t     cmpop,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic        br_en
);

    always_comb begin
        case (cmpop)
            cmp_beq:  br_en = (a == b);
            cmp_bne:  br_en = (a != b);
            cmp_blt:  br_en = ($signed(a) < $signed(b));
            cmp_bge:  br_en = ($signed(a) >= $signed(b));
            cmp_bltu: br_en = (a < b);
            cmp_bgeu: br_en = (a >= b);
            default:  br_en = 1'b0;
        endcase
    end

endmodule : cmp

// ==== logic/exec_cluster.sv ====
module exec_cluster
    import exec_pkg::*;
#(
    parameter int SS = 2
)
(
    input  logic    clk,
    input  logic    rst,

    // Issue from the reservation station, one port per lane
    input  logic    issue_valid [SS],
    output logic    issue_ready [SS],
    input  issue_t  issue_inst  [SS],

    // Common data bus toward the reorder buffer
    output logic    cdb_valid,
    input  logic    cdb_ready,
    output result_t cdb_result
);

    cdb_lane_if lane_bus [SS] ();

    for (genvar i = 0; i < SS; i++) begin : g_fu
        fu_wrapper u_fu (
            .clk         (clk),
            .rst         (rst),
            .issue_valid (issue_valid[i]),
            .issue_ready (issue_ready[i]),
            .issue_inst  (issue_inst[i]),
            .cdb         (lane_bus[i])
        );
    end

    cdb_arbiter #(
        .SS (SS)
    ) u_arb (
        .clk        (clk),
        .rst        (rst),
        .lanes      (lane_bus),
        .cdb_valid  (cdb_valid),
        .cdb_ready  (cdb_ready),
        .cdb_result (cdb_result)
    );

endmodule : exec_cluster

// ==== logic/exec_pkg.sv ====
package exec_pkg;

    import rv32_pkg::*;

    localparam int TAG_W     = 3;
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    // Reorder-buffer tag
    typedef logic [TAG_W-1:0] tag_t;

    // One decoded instruction with its operands already read
    typedef struct packed {
        tag_t                 tag;
        op_class_t            op_class;
        logic                 alu_en;
        logic                 cmp_en;
        logic                 is_mul;
        alu_op_t              alu_operation;
        cmp_op_t              cmp_operation;
        mul_type_t            mul_type;
        logic [REG_IDX_W-1:0] rs1_s;
        logic [REG_IDX_W-1:0] rs2_s;
        logic                 op1_is_pc;
        logic                 op2_is_imm;
        logic [XLEN-1:0]      immediate;
        logic [XLEN-1:0]      pc_curr;
        logic [XLEN-1:0]      rs1_value;
        logic [XLEN-1:0]      rs2_value;
    } issue_t;

    // Finished result headed for the reorder buffer
    typedef struct packed {
        tag_t            tag;
        logic [XLEN-1:0] register_value;
        logic            br_en;
    } result_t;

endpackage : exec_pkg

// ==== logic/fu_wrapper.sv ====
module fu_wrapper
    import rv32_pkg::*;
    import exec_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   issue_valid,
    output logic   issue_ready,
    input  issue_t issue_inst,
    cdb_lane_if.lane cdb
);

    logic [31:0] rs1_reg;
    logic [31:0] rs2_reg;
    logic [31:0] op_a;
    logic [31:0] op_b;

    logic [31:0] alu_out;
    logic        cmp_out;
    logic [63:0] mul_p;
    logic        mul_done;
    logic        mul_busy;

    logic        accept;
    logic        slot_valid;
    result_t     slot_result;

    // Held for the multiply while it runs
    tag_t        pend_tag;
    mul_type_t   pend_mul_type;

    // x0 always reads as zero
    assign rs1_reg = (issue_inst.rs1_s == '0) ? '0 : issue_inst.rs1_value;
    assign rs2_reg = (issue_inst.rs2_s == '0) ? '0 : issue_inst.rs2_value;

    always_comb begin
        // auipc, branch and jump add to the PC
        op_a = issue_inst.op1_is_pc ? issue_inst.pc_curr : rs1_reg;

        // Jumps write back the return address pc + 4
        if (issue_inst.op_class == op_jump) begin
            op_b = 32'd4;
        end else if (issue_inst.op2_is_imm) begin
            op_b = issue_inst.immediate;
        end else begin
            op_b = rs2_reg;
        end
    end

    alu u_alu (
        .aluop (issue_inst.alu_operation),
        .a     (op_a),
        .b     (op_b),
        .f     (alu_out)
    );

    // Comparator always sees the register operands
    cmp u_cmp (
        .cmpop (issue_inst.cmp_operation),
        .a     (rs1_reg),
        .b     (rs2_reg),
        .br_en (cmp_out)
    );

    shift_add_multiplier u_mul (
        .clk      (clk),
        .rst      (rst),
        .start    (accept && issue_inst.is_mul),
        .mul_type (issue_inst.mul_type),
        .a        (rs1_reg),
        .b        (rs2_reg),
        .p        (mul_p),
        .done     (mul_done),
        .busy     (mul_busy)
    );

    // One instruction in flight, slot may drain in the same cycle
    assign issue_ready = !mul_busy && (!slot_valid || cdb.ready);
    assign accept      = issue_valid && issue_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= 1'b0;
        end else if ((accept && !issue_inst.is_mul) || mul_done) begin
            slot_valid <= 1'b1;
        end else if (cdb.ready) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && issue_inst.is_mul) begin
            pend_tag      <= issue_inst.tag;
            pend_mul_type <= issue_inst.mul_type;
        end

        if (accept && !issue_inst.is_mul) begin
            slot_result.tag            <= issue_inst.tag;
            slot_result.register_value <= issue_inst.alu_en ? alu_out : '0;
            slot_result.br_en          <= issue_inst.cmp_en && cmp_out;
        end else if (mul_done) begin
            slot_result.tag            <= pend_tag;
            // mul keeps the low word, the mulh kinds the high word
            slot_result.register_value <= (pend_mul_type == mul_mul) ? mul_p[31:0]
                                                                     : mul_p[63:32];
            slot_result.br_en          <= 1'b0;
        end
    end

    assign cdb.valid  = slot_valid;
    assign cdb.result = slot_result;

endmodule : fu_wrapper

// ==== logic/rv32_pkg.sv ====
package rv32_pkg;

    // ALU operations, funct3 in bits [2:0] and funct7[5] in bit 3
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    // Branch conditions, same codes as the branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    // RV32M multiply kinds, funct3[1:0]
    typedef enum logic [1:0] {
        mul_mul    = 2'b00,
        mul_mulh   = 2'b01,
        mul_mulhsu = 2'b10,
        mul_mulhu  = 2'b11
    } mul_type_t;

    // Instruction classes as seen by the execute stage
    typedef enum logic [2:0] {
        op_reg    = 3'd0,
        op_imm    = 3'd1,
        op_auipc  = 3'd2,
        op_lui    = 3'd3,
        op_branch = 3'd4,
        op_jump   = 3'd5
    } op_class_t;

endpackage : rv32_pkg

// ==== logic/shift_add_multiplier.sv ====
module shift_add_multiplier
    import rv32_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  mul_type_t   mul_type,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [63:0] p,
    output logic        done,
    output logic        busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } state_t;

    state_t      state;
    logic [4:0]  count;
    logic [63:0] acc;
    logic [63:0] mcand;
    logic [31:0] mplier;
    logic        neg;

    logic        a_neg;
    logic        b_neg;
    logic [31:0] mag_a;
    logic [31:0] mag_b;

    // rs1 is signed for all but mulhu, rs2 only for mul and mulh
    assign a_neg = (mul_type != mul_mulhu) && a[31];
    assign b_neg = ((mul_type == mul_mul) || (mul_type == mul_mulh)) && b[31];
    assign mag_a = a_neg ? (~a + 32'd1) : a;
    assign mag_b = b_neg ? (~b + 32'd1) : b;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                        count <= '0;
                    end
                end
                st_run: begin
                    // 32 iterations, one multiplier bit each
                    if (count == 5'd31) begin
                        state <= st_done;
                    end
                    count <= count + 5'd1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && start) begin
            acc    <= '0;
            mcand  <= {32'b0, mag_a};
            mplier <= mag_b;
            neg    <= a_neg ^ b_neg;
        end else if (state == st_run) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Sign goes back on the magnitude product during the done cycle
    assign p    = neg ? (~acc + 64'd1) : acc;
    assign done = (state == st_done);
    assign busy = (state != st_idle);

endmodule : shift_add_multiplier

// ==== run_sim.sh ====
#!/bin/sh
# Build the exec_cluster testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module exec_cluster_tb -f exec_cluster.f \
    -o exec_cluster_sim && ./obj_dir/exec_cluster_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation PASSED" sim.log && exit 0 || exit 1
